// ==== rtl/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
  parameter int RAM_WORDS = 256
) (
  input  logic  clk,
  input  logic  rst,
  wb_if.slave   wb
);

  // Word index width, RAM_WORDS is a power of two so higher bits wrap
  localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  logic [mem_pkg::XLEN-1:0]   mem [RAM_WORDS];
  logic [AW-1:0]              word_idx;
  logic                       strobe;

  assign word_idx = wb.adr[3 +: AW];

  // First cycle of a new bus access
  assign strobe = wb.cyc && wb.stb && !wb.ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb.ack <= 1'b0;
    end else begin
      wb.ack <= strobe;
    end
  end

  always_ff @(posedge clk) begin
    if (strobe) begin
      wb.dat_r <= mem[word_idx];
      if (wb.we) begin
        for (int b = 0; b < mem_pkg::XLEN/8; b++) begin
          if (wb.sel[b]) begin
            mem[word_idx][8*b +: 8] <= wb.dat_w[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

  // Data and register width of the core
  parameter int XLEN = 64;

  // Memory operation presented by the pipeline
  typedef enum logic [3:0] {
    OP_NONE = 4'd0,
    OP_LB   = 4'd1,
    OP_LH   = 4'd2,
    OP_LW   = 4'd3,
    OP_LD   = 4'd4,
    OP_LBU  = 4'd5,
    OP_LHU  = 4'd6,
    OP_LWU  = 4'd7,
    OP_SB   = 4'd8,
    OP_SH   = 4'd9,
    OP_SW   = 4'd10,
    OP_SD   = 4'd11
  } mem_op_e;

  // Exception returned with a response
  typedef enum logic [1:0] {
    EXCP_NONE             = 2'd0,
    EXCP_LOAD_MISALIGNED  = 2'd1,
    EXCP_STORE_MISALIGNED = 2'd2
  } mem_excp_e;

endpackage

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
  input  mem_pkg::mem_op_e            op,
  input  logic [mem_pkg::XLEN-1:0]    mem_addr,
  input  logic [mem_pkg::XLEN-1:0]    r_data2,
  input  logic [mem_pkg::XLEN-1:0]    ram_rd_data,
  output logic [mem_pkg::XLEN-1:0]    mem_data,
  output logic [mem_pkg::XLEN-1:0]    ram_wr_data,
  output logic [7:0]                  byte_enable,
  output mem_pkg::mem_excp_e          mem_excp
);

  logic                       is_load;
  logic                       is_store;
  logic                       is_signed;
  logic [1:0]                 size;
  logic [2:0]                 offset;
  logic                       misaligned;
  logic [7:0]                 size_mask;
  logic [mem_pkg::XLEN-1:0]   mem_part;
  logic [mem_pkg::XLEN-1:0]   load_val;

  assign offset = mem_addr[2:0];

  // Size is log2 of the access width in bytes
  always_comb begin
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_signed = 1'b0;
    size      = 2'd0;
    case (op)
      mem_pkg::OP_LB:  begin is_load = 1'b1; is_signed = 1'b1; size = 2'd0; end
      mem_pkg::OP_LH:  begin is_load = 1'b1; is_signed = 1'b1; size = 2'd1; end
      mem_pkg::OP_LW:  begin is_load = 1'b1; is_signed = 1'b1; size = 2'd2; end
      mem_pkg::OP_LD:  begin is_load = 1'b1; size = 2'd3; end
      mem_pkg::OP_LBU: begin is_load = 1'b1; size = 2'd0; end
      mem_pkg::OP_LHU: begin is_load = 1'b1; size = 2'd1; end
      mem_pkg::OP_LWU: begin is_load = 1'b1; size = 2'd2; end
      mem_pkg::OP_SB:  begin is_store = 1'b1; size = 2'd0; end
      mem_pkg::OP_SH:  begin is_store = 1'b1; size = 2'd1; end
      mem_pkg::OP_SW:  begin is_store = 1'b1; size = 2'd2; end
      mem_pkg::OP_SD:  begin is_store = 1'b1; size = 2'd3; end
      default: ;
    endcase
  end

  always_comb begin
    case (size)
      2'd0:    begin misaligned = 1'b0;          size_mask = 8'h01; end
      2'd1:    begin misaligned = offset[0];     size_mask = 8'h03; end
      2'd2:    begin misaligned = |offset[1:0];  size_mask = 8'h0f; end
      default: begin misaligned = |offset;       size_mask = 8'hff; end
    endcase
  end

  // Load lane extraction and extension
  assign mem_part = ram_rd_data >> {offset, 3'b0};

  always_comb begin
    case (size)
      2'd0:    load_val = {{(mem_pkg::XLEN-8){is_signed & mem_part[7]}}, mem_part[7:0]};
      2'd1:    load_val = {{(mem_pkg::XLEN-16){is_signed & mem_part[15]}}, mem_part[15:0]};
      2'd2:    load_val = {{(mem_pkg::XLEN-32){is_signed & mem_part[31]}}, mem_part[31:0]};
      default: load_val = mem_part;
    endcase
  end

  assign mem_data = is_load ? load_val : '0;

  // Store lanes and byte enables, none on a misaligned access
  assign ram_wr_data = r_data2 << {offset, 3'b0};
  assign byte_enable = ((is_load || is_store) && !misaligned) ? (size_mask << offset) : 8'h00;

  always_comb begin
    if (misaligned && is_load) begin
      mem_excp = mem_pkg::EXCP_LOAD_MISALIGNED;
    end else if (misaligned && is_store) begin
      mem_excp = mem_pkg::EXCP_STORE_MISALIGNED;
    end else begin
      mem_excp = mem_pkg::EXCP_NONE;
    end
  end

endmodule

// ==== rtl/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top #(
  parameter int RAM_WORDS = 256
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        req_valid,
  output logic                        req_ready,
  input  logic [3:0]                  req_op,
  input  logic [mem_pkg::XLEN-1:0]    req_addr,
  input  logic [mem_pkg::XLEN-1:0]    req_wdata,
  output logic                        resp_valid,
  output logic [mem_pkg::XLEN-1:0]    resp_data,
  output logic [1:0]                  resp_excp
);

  mem_pkg::mem_op_e     req_op_e;
  mem_pkg::mem_excp_e   resp_excp_e;

  // Raw port bits to and from the package enums
  assign req_op_e  = mem_pkg::mem_op_e'(req_op);
  assign resp_excp = 2'(resp_excp_e);

  wb_if i_wb ();

  mem_wb_master i_mem_wb_master (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_op     (req_op_e),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .resp_excp  (resp_excp_e),
    .wb         (i_wb.master)
  );

  data_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) i_data_ram (
    .clk (clk),
    .rst (rst),
    .wb  (i_wb.slave)
  );

endmodule

// ==== rtl/mem_wb_master.sv ====
`timescale 1ns/1ps

module mem_wb_master (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        req_valid,
  output logic                        req_ready,
  input  mem_pkg::mem_op_e            req_op,
  input  logic [mem_pkg::XLEN-1:0]    req_addr,
  input  logic [mem_pkg::XLEN-1:0]    req_wdata,
  output logic                        resp_valid,
  output logic [mem_pkg::XLEN-1:0]    resp_data,
  output mem_pkg::mem_excp_e          resp_excp,
  wb_if.master                        wb
);

  typedef enum logic [1:0] {
    IDLE,
    BUS,
    RESP
  } state_e;

  state_e                     state;
  state_e                     next_state;
  logic                       accept;
  logic                       skip_bus;

  mem_pkg::mem_op_e           op_q;
  logic [mem_pkg::XLEN-1:0]   addr_q;
  logic [mem_pkg::XLEN-1:0]   wdata_q;

  mem_pkg::mem_op_e           stage_op;
  logic [mem_pkg::XLEN-1:0]   stage_addr;
  logic [mem_pkg::XLEN-1:0]   stage_wdata;
  logic [mem_pkg::XLEN-1:0]   stage_data;
  logic [mem_pkg::XLEN-1:0]   stage_wr_data;
  logic [7:0]                 stage_be;
  mem_pkg::mem_excp_e         stage_excp;

  assign accept = req_valid && req_ready;

  // Live request is decoded in IDLE so the bus decision is made at acceptance
  assign stage_op    = (state == IDLE) ? req_op    : op_q;
  assign stage_addr  = (state == IDLE) ? req_addr  : addr_q;
  assign stage_wdata = (state == IDLE) ? req_wdata : wdata_q;

  mem_stage i_mem_stage (
    .op          (stage_op),
    .mem_addr    (stage_addr),
    .r_data2     (stage_wdata),
    .ram_rd_data (wb.dat_r),
    .mem_data    (stage_data),
    .ram_wr_data (stage_wr_data),
    .byte_enable (stage_be),
    .mem_excp    (stage_excp)
  );

  assign skip_bus = (stage_excp != mem_pkg::EXCP_NONE) || (stage_op == mem_pkg::OP_NONE);

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (accept) begin
          next_state = skip_bus ? RESP : BUS;
        end
      end
      BUS: begin
        if (wb.ack) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  // Ready is registered so it stays low through reset and the cycle after
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      req_ready  <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      state      <= next_state;
      req_ready  <= (next_state == IDLE);
      resp_valid <= ((state == BUS) && wb.ack) || (state == RESP);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q    <= req_op;
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
    end
    if ((state == BUS) && wb.ack) begin
      resp_data <= stage_data;
      resp_excp <= mem_pkg::EXCP_NONE;
    end else if (state == RESP) begin
      resp_data <= '0;
      resp_excp <= stage_excp;
    end
  end

  // Bus outputs stay stable in BUS because they come from the held request
  assign wb.cyc   = (state == BUS);
  assign wb.stb   = (state == BUS);
  assign wb.we    = (state == BUS) &&
                    (op_q inside {mem_pkg::OP_SB, mem_pkg::OP_SH, mem_pkg::OP_SW, mem_pkg::OP_SD});
  assign wb.adr   = {addr_q[mem_pkg::XLEN-1:3], 3'b000};
  assign wb.dat_w = stage_wr_data;
  assign wb.sel   = stage_be;

endmodule

// ==== rtl/wb_if.sv ====
`timescale 1ns/1ps

interface wb_if;

  logic                         cyc;
  logic                         stb;
  logic                         we;
  logic [mem_pkg::XLEN-1:0]     adr;
  logic [mem_pkg::XLEN-1:0]     dat_w;
  // One select bit per byte lane
  logic [mem_pkg::XLEN/8-1:0]   sel;
  logic [mem_pkg::XLEN-1:0]     dat_r;
  logic                         ack;

  modport master (
    output cyc, stb, we, adr, dat_w, sel,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w, sel,
    output dat_r, ack
  );

endinterface

// ==== run.sh ====
#!/bin/sh
# Build with Verilator from tb.f, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --top-module tb_mem_subsys -f tb.f -o tb_mem_subsys_sim \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_mem_subsys_sim > sim.log 2>&1
grep -qx "TEST RESULT: PASS" sim.log && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== tb.f ====
rtl/mem_pkg.sv
rtl/wb_if.sv
rtl/mem_stage.sv
rtl/mem_wb_master.sv
rtl/data_ram.sv
rtl/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

// ==== testbench/tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys;

  localparam int CLK_PERIOD = 20;
  localparam int NUM_RANDOM = 300;
  // Reset/none, SD+LD pairs, random region fill, lanes, extension, misaligned
  localparam int NUM_DIRECTED = 2 + 16 + 32 + 29 + 29 + 36;
  localparam int WATCHDOG_CYCLES = 10 * (NUM_DIRECTED + NUM_RANDOM) + 100;

  localparam logic [63:0] LANE_ADDR = 64'h140;
  localparam logic [63:0] EXT_ADDR  = 64'h148;
  localparam logic [63:0] MIS_ADDR  = 64'h150;

  logic         clk;
  logic         rst;
  logic         req_valid;
  logic         req_ready;
  logic [3:0]   req_op;
  logic [63:0]  req_addr;
  logic [63:0]  req_wdata;
  logic         resp_valid;
  logic [63:0]  resp_data;
  logic [1:0]   resp_excp;

  integer       seed;
  int           cycle;

  // Byte image of the RAM indexed by address bits 10 to 0
  logic [7:0]   model_mem [2048];

  logic [63:0]  exp_data_q [$];
  logic [1:0]   exp_excp_q [$];
  int           exp_lat_q [$];
  int           accept_cyc_q [$];

  mem_subsys_top #(
    .RAM_WORDS (256)
  ) i_mem_subsys_top (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .resp_excp  (resp_excp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] time %0t: %s mismatch, got 0x%016h, expected 0x%016h",
                          $time, what, got, exp));
    end
  endtask

  function automatic int access_bytes(input logic [3:0] op);
    case (op)
      mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_SB: return 1;
      mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH: return 2;
      mem_pkg::OP_LW, mem_pkg::OP_LWU, mem_pkg::OP_SW: return 4;
      mem_pkg::OP_LD, mem_pkg::OP_SD:                  return 8;
      default:                                         return 0;
    endcase
  endfunction

  function automatic bit is_store_op(input logic [3:0] op);
    return op inside {mem_pkg::OP_SB, mem_pkg::OP_SH, mem_pkg::OP_SW, mem_pkg::OP_SD};
  endfunction

  function automatic bit is_signed_load(input logic [3:0] op);
    return op inside {mem_pkg::OP_LB, mem_pkg::OP_LH, mem_pkg::OP_LW};
  endfunction

  function automatic logic [3:0] store_op_for(input int nbytes);
    case (nbytes)
      1:       return mem_pkg::OP_SB;
      2:       return mem_pkg::OP_SH;
      4:       return mem_pkg::OP_SW;
      default: return mem_pkg::OP_SD;
    endcase
  endfunction

  function automatic logic [3:0] load_op_for(input int nbytes, input bit sext);
    case (nbytes)
      1:       return sext ? mem_pkg::OP_LB : mem_pkg::OP_LBU;
      2:       return sext ? mem_pkg::OP_LH : mem_pkg::OP_LHU;
      4:       return sext ? mem_pkg::OP_LW : mem_pkg::OP_LWU;
      default: return mem_pkg::OP_LD;
    endcase
  endfunction

  // Expected response data and exception from the alignment rule and the model
  function automatic logic [63:0] ref_access(input logic [3:0] op, input logic [63:0] addr,
                                             output logic [1:0] excp);
    int          nbytes;
    logic [10:0] bidx;
    logic [63:0] val;
    logic        sign;
    nbytes = access_bytes(op);
    val = '0;
    excp = mem_pkg::EXCP_NONE;
    if (nbytes == 0) begin
      return '0;
    end
    if ((addr[2:0] & 3'(nbytes - 1)) != 3'b000) begin
      excp = is_store_op(op) ? mem_pkg::EXCP_STORE_MISALIGNED : mem_pkg::EXCP_LOAD_MISALIGNED;
      return '0;
    end
    if (is_store_op(op)) begin
      return '0;
    end
    for (int k = 0; k < nbytes; k++) begin
      bidx = addr[10:0] + 11'(k);
      val[8*k +: 8] = model_mem[bidx];
    end
    if (is_signed_load(op)) begin
      sign = val[8*nbytes-1];
      for (int i = 8 * nbytes; i < 64; i++) begin
        val[i] = sign;
      end
    end
    return val;
  endfunction

  task automatic model_write(input logic [3:0] op, input logic [63:0] addr,
                             input logic [63:0] wdata);
    logic [10:0] bidx;
    for (int k = 0; k < access_bytes(op); k++) begin
      bidx = addr[10:0] + 11'(k);
      model_mem[bidx] = wdata[8*k +: 8];
    end
  endtask

  // One request, held until accepted, then wait for its response
  task automatic send_req(input logic [3:0] op, input logic [63:0] addr,
                          input logic [63:0] wdata, input int gap);
    logic [63:0] exp_data;
    logic [1:0]  exp_excp;
    repeat (gap) @(posedge clk);
    exp_data = ref_access(op, addr, exp_excp);
    req_valid <= 1'b1;
    req_op    <= op;
    req_addr  <= addr;
    req_wdata <= wdata;
    @(posedge clk);
    while (req_ready !== 1'b1) @(posedge clk);
    exp_data_q.push_back(exp_data);
    exp_excp_q.push_back(exp_excp);
    accept_cyc_q.push_back(cycle);
    if (op == mem_pkg::OP_NONE || exp_excp != mem_pkg::EXCP_NONE) begin
      exp_lat_q.push_back(2);
    end else begin
      exp_lat_q.push_back(3);
    end
    if (is_store_op(op) && exp_excp == mem_pkg::EXCP_NONE) begin
      model_write(op, addr, wdata);
    end
    req_valid <= 1'b0;
    @(posedge clk);
    while (resp_valid !== 1'b1) @(posedge clk);
  endtask

  // Response checker
  initial begin
    logic [63:0] d;
    logic [1:0]  e;
    int          lat;
    int          acc;
    forever begin
      @(posedge clk);
      if (resp_valid === 1'b1) begin
        if (exp_data_q.size() == 0) begin
          abort_run("A response arrived while no request was outstanding");
        end else begin
          d   = exp_data_q.pop_front();
          e   = exp_excp_q.pop_front();
          lat = exp_lat_q.pop_front();
          acc = accept_cyc_q.pop_front();
          check_value("resp_data", resp_data, d);
          check_value("resp_excp", {62'b0, resp_excp}, {62'b0, e});
          check_value("response latency", 64'(cycle - acc), 64'(lat));
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run($sformatf("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES));
  end

  initial begin
    logic [3:0]  op;
    logic [63:0] addr;
    logic [63:0] wdata;
    int          gap;
    seed      = 46569;
    rst       <= 1'b1;
    req_valid <= 1'b0;
    req_op    <= 4'd0;
    req_addr  <= 64'd0;
    req_wdata <= 64'd0;

    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_value("resp_valid after reset", 64'(resp_valid), 64'd0);
    check_value("req_ready in first cycle after reset", 64'(req_ready), 64'd0);
    @(posedge clk);
    check_value("req_ready when idle", 64'(req_ready), 64'd1);
    send_req(mem_pkg::OP_NONE, 64'h1234, 64'hdead_beef, 0);
    send_req(mem_pkg::OP_NONE, 64'h7, 64'h1, 1);

    // Upper address bits wrap onto words 200 to 207
    for (int i = 0; i < 8; i++) begin
      addr  = (64'(i) << 40) | (64'(200 + i) << 3);
      wdata = {$random(seed), $random(seed)};
      send_req(mem_pkg::OP_SD, addr, wdata, 0);
      send_req(mem_pkg::OP_LD, 64'(200 + i) << 3, 64'd0, 0);
    end

    // Words 0 to 31 serve the random phase
    for (int w = 0; w < 32; w++) begin
      wdata = {$random(seed), $random(seed)};
      send_req(mem_pkg::OP_SD, 64'(w) << 3, wdata, 0);
    end

    send_req(mem_pkg::OP_SD, LANE_ADDR, 64'h0123_4567_89ab_cdef, 0);
    for (int sz = 1; sz <= 4; sz = sz * 2) begin
      for (int off = 0; off < 8; off = off + sz) begin
        wdata = {$random(seed), $random(seed)};
        send_req(store_op_for(sz), LANE_ADDR + 64'(off), wdata, 0);
        send_req(mem_pkg::OP_LD, LANE_ADDR, 64'd0, 0);
      end
    end

    // Every byte has its top bit set
    send_req(mem_pkg::OP_SD, EXT_ADDR, 64'hf0e1_d2c3_b4a5_9687, 0);
    for (int sz = 1; sz <= 4; sz = sz * 2) begin
      for (int off = 0; off < 8; off = off + sz) begin
        send_req(load_op_for(sz, 1'b1), EXT_ADDR + 64'(off), 64'd0, 0);
        send_req(load_op_for(sz, 1'b0), EXT_ADDR + 64'(off), 64'd0, 0);
      end
    end

    send_req(mem_pkg::OP_SD, MIS_ADDR, {$random(seed), $random(seed)}, 0);
    for (int sz = 2; sz <= 8; sz = sz * 2) begin
      for (int off = 1; off < 8; off++) begin
        if (off % sz != 0) begin
          send_req(load_op_for(sz, 1'b1), MIS_ADDR + 64'(off), 64'd0, 0);
          send_req(store_op_for(sz), MIS_ADDR + 64'(off), 64'hffff_ffff_ffff_ffff, 0);
        end
      end
    end
    send_req(mem_pkg::OP_LD, MIS_ADDR, 64'd0, 0);

    for (int n = 0; n < NUM_RANDOM; n++) begin
      op    = 4'({$random(seed)} % 12);
      addr  = {$random(seed), $random(seed)};
      addr[10:8] = 3'b000;
      wdata = {$random(seed), $random(seed)};
      gap   = {$random(seed)} % 4;
      send_req(op, addr, wdata, gap);
    end

    repeat (2) @(posedge clk);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
